//--- verilog/soc_pkg.sv
////////////////////////////////////////////////////////////
// shared bus types and memory map for the platform fabric
// the region is taken from address bits 31:28 only
////////////////////////////////////////////////////////////

package soc_pkg;

    localparam int XLEN      = 32;
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);   // word index bits
    localparam int IRQ_COUNT = 2;                   // source ids 1..IRQ_COUNT

    // region boundaries on the top address nibble
    localparam logic [3:0] TIMER_BASE  = 4'h2;      // ram below this
    localparam logic [3:0] IRQ_BASE    = 4'h3;
    localparam logic [3:0] PERIPH_BASE = 4'h8;      // up to nibble f

    // timer register offsets
    localparam logic [3:0] MTIME_LO    = 4'h0;
    localparam logic [3:0] MTIME_HI    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO = 4'h8;
    localparam logic [3:0] MTIMECMP_HI = 4'hC;

    // interrupt controller and button offsets
    localparam logic [3:0] IRQ_ENABLE  = 4'h0;
    localparam logic [3:0] IRQ_PENDING = 4'h4;
    localparam logic [3:0] IRQ_CLAIM   = 4'h8;
    localparam logic [3:0] BTN_STATUS  = 4'h0;

    typedef struct packed {
        logic            en;        // request strobe
        logic [3:0]      be;        // zero means read
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic ram;
        logic timer;
        logic irq;
        logic periph;
    } dev_sel_t;

    typedef enum logic [1:0] {
        REGION_RAM    = 2'd0,
        REGION_TIMER  = 2'd1,
        REGION_IRQ    = 2'd2,
        REGION_PERIPH = 2'd3
    } region_e;

endpackage

//--- verilog/bus_fabric.sv
////////////////////////////////////////////////////////////
// every device answers one cycle after its request, so the
// registered region is enough to steer the read data
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bus_fabric (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::dev_sel_t sel_o,
    input  logic [31:0]       ram_rdata_i,
    input  logic [31:0]       tmr_rdata_i,
    input  logic [31:0]       irq_rdata_i,
    input  logic [31:0]       btn_rdata_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    soc_pkg::region_e region_d;
    soc_pkg::region_e region_q;
    logic             valid_q;
    logic [3:0]       nibble;

    assign nibble = req_i.addr[31:28];

    ////////////////////////////////////////////////////////////
    // decode stage
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (nibble < soc_pkg::TIMER_BASE) begin
            region_d = soc_pkg::REGION_RAM;
        end else if (nibble < soc_pkg::IRQ_BASE) begin
            region_d = soc_pkg::REGION_TIMER;
        end else if (nibble < soc_pkg::PERIPH_BASE) begin
            region_d = soc_pkg::REGION_IRQ;
        end else begin
            region_d = soc_pkg::REGION_PERIPH;
        end
    end

    always_comb begin
        sel_o        = '0;
        sel_o.ram    = req_i.en && (region_d == soc_pkg::REGION_RAM);
        sel_o.timer  = req_i.en && (region_d == soc_pkg::REGION_TIMER);
        sel_o.irq    = req_i.en && (region_d == soc_pkg::REGION_IRQ);
        sel_o.periph = req_i.en && (region_d == soc_pkg::REGION_PERIPH);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            region_q <= soc_pkg::REGION_RAM;
        end else begin
            valid_q <= req_i.en;
            if (req_i.en) begin
                region_q <= region_d;   // idle cycles keep last region
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // return stage
    ////////////////////////////////////////////////////////////
    always_comb begin
        rsp_o.valid = valid_q;
        case (region_q)
            soc_pkg::REGION_TIMER:  rsp_o.rdata = tmr_rdata_i;
            soc_pkg::REGION_IRQ:    rsp_o.rdata = irq_rdata_i;
            soc_pkg::REGION_PERIPH: rsp_o.rdata = btn_rdata_i;
            default:                rsp_o.rdata = ram_rdata_i;
        endcase
    end

endmodule

//--- verilog/scratch_ram.sv
////////////////////////////////////////////////////////////
// word addresses wrap above RAM_WORDS, contents start unknown
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module scratch_ram (
    input  logic              clk,
    input  soc_pkg::bus_req_t req_i,
    input  logic              sel_i,
    output logic [31:0]       rdata_o
);

    logic [3:0][7:0]            mem [soc_pkg::RAM_WORDS];
    logic [soc_pkg::RAM_AW-1:0] word_idx;
    logic                       wr;
    logic                       rd;
    logic [31:0]                rdata_q;

    assign word_idx = req_i.addr[soc_pkg::RAM_AW+1:2];  // upper bits ignored
    assign wr       = sel_i && (req_i.be != 4'b0000);
    assign rd       = sel_i && (req_i.be == 4'b0000);

    // byte lane writes
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    mem[word_idx][b] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rdata_q <= mem[word_idx];   // held when not selected
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- verilog/machine_timer.sv
////////////////////////////////////////////////////////////
// 32-bit bus access to each half of mtime and mtimecmp
// a write to mtime takes the place of that cycle's increment
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module machine_timer (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    input  logic              sel_i,
    output logic [31:0]       rdata_o,
    output logic              mti_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        mti_q;
    logic [31:0] rdata_q;
    logic [3:0]  offset;
    logic        wr;
    logic        rd;

    assign offset = req_i.addr[3:0];
    assign wr     = sel_i && (req_i.be != 4'b0000);
    assign rd     = sel_i && (req_i.be == 4'b0000);

    function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // counter, compare and interrupt
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtime_q    <= 64'd0;
            mtimecmp_q <= '1;            // no interrupt until programmed
            mti_q      <= 1'b0;
        end else begin
            mti_q <= (mtime_q >= mtimecmp_q);
            if (wr && offset == soc_pkg::MTIME_LO) begin
                mtime_q[31:0] <= byte_merge(mtime_q[31:0], req_i.wdata, req_i.be);
            end else if (wr && offset == soc_pkg::MTIME_HI) begin
                mtime_q[63:32] <= byte_merge(mtime_q[63:32], req_i.wdata, req_i.be);
            end else begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr && offset == soc_pkg::MTIMECMP_LO) begin
                mtimecmp_q[31:0] <= byte_merge(mtimecmp_q[31:0], req_i.wdata, req_i.be);
            end
            if (wr && offset == soc_pkg::MTIMECMP_HI) begin
                mtimecmp_q[63:32] <= byte_merge(mtimecmp_q[63:32], req_i.wdata, req_i.be);
            end
        end
    end

    // value seen at the request edge
    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                soc_pkg::MTIME_LO:    rdata_q <= mtime_q[31:0];
                soc_pkg::MTIME_HI:    rdata_q <= mtime_q[63:32];
                soc_pkg::MTIMECMP_LO: rdata_q <= mtimecmp_q[31:0];
                soc_pkg::MTIMECMP_HI: rdata_q <= mtimecmp_q[63:32];
                default:              rdata_q <= 32'd0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign mti_o   = mti_q;

endmodule

//--- verilog/irq_controller.sv
////////////////////////////////////////////////////////////
// bit n of enable and pending belongs to source id n, bit 0 unused
// claim reads return the lowest active id, zero when idle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module irq_controller (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  soc_pkg::bus_req_t           req_i,
    input  logic                        sel_i,
    input  logic [soc_pkg::IRQ_COUNT:1] src_i,
    output logic [31:0]                 rdata_o,
    output logic                        mei_o
);

    logic [soc_pkg::IRQ_COUNT:1] enable_q;
    logic [soc_pkg::IRQ_COUNT:1] pending_q;
    logic [soc_pkg::IRQ_COUNT:1] active;
    logic [soc_pkg::IRQ_COUNT:1] claim_mask;
    logic [soc_pkg::IRQ_COUNT:1] clear_mask;
    logic [31:0]                 claim_id;
    logic [31:0]                 rd_word;
    logic [31:0]                 rdata_q;
    logic [3:0]                  offset;
    logic                        wr;
    logic                        rd;

    assign offset = req_i.addr[3:0];
    assign wr     = sel_i && (req_i.be != 4'b0000);
    assign rd     = sel_i && (req_i.be == 4'b0000);
    assign active = pending_q & enable_q;

    // lowest id wins, scanned from the top down
    always_comb begin
        claim_id   = 32'd0;
        claim_mask = '0;
        for (int i = soc_pkg::IRQ_COUNT; i >= 1; i--) begin
            if (active[i]) begin
                claim_id      = 32'(i);
                claim_mask    = '0;
                claim_mask[i] = 1'b1;
            end
        end
    end

    always_comb begin
        clear_mask = '0;
        if (rd && offset == soc_pkg::IRQ_CLAIM) begin
            clear_mask = claim_mask;                    // claim acks the source
        end
        if (wr && offset == soc_pkg::IRQ_PENDING) begin
            clear_mask = clear_mask | req_i.wdata[soc_pkg::IRQ_COUNT:1];  // write one to clear
        end
    end

    ////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            enable_q  <= '0;
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clear_mask) | src_i;   // new pulse wins
            if (wr && offset == soc_pkg::IRQ_ENABLE) begin
                enable_q <= req_i.wdata[soc_pkg::IRQ_COUNT:1];
            end
        end
    end

    always_comb begin
        rd_word = 32'd0;
        case (offset)
            soc_pkg::IRQ_ENABLE:  rd_word[soc_pkg::IRQ_COUNT:1] = enable_q;
            soc_pkg::IRQ_PENDING: rd_word[soc_pkg::IRQ_COUNT:1] = pending_q;
            soc_pkg::IRQ_CLAIM:   rd_word = claim_id;
            default:              rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata_o = rdata_q;
    assign mei_o   = |active;   // straight from the registers

endmodule

//--- verilog/button_port.sv
////////////////////////////////////////////////////////////
// btn_i may be asynchronous, press and release pulses last one cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module button_port (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  soc_pkg::bus_req_t           req_i,
    input  logic                        sel_i,
    input  logic                        btn_i,
    output logic [31:0]                 rdata_o,
    output logic [soc_pkg::IRQ_COUNT:1] irq_o
);

    logic        sync1_q;
    logic        sync2_q;   // synchronized level
    logic        prev_q;    // level one cycle earlier
    logic        press_q;
    logic        release_q;
    logic [7:0]  count_q;
    logic [31:0] rdata_q;
    logic        status_hit;

    assign status_hit = sel_i && (req_i.addr[3:0] == soc_pkg::BTN_STATUS);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sync1_q   <= 1'b0;
            sync2_q   <= 1'b0;
            prev_q    <= 1'b0;
            press_q   <= 1'b0;
            release_q <= 1'b0;
            count_q   <= 8'd0;
        end else begin
            sync1_q   <= btn_i;
            sync2_q   <= sync1_q;
            prev_q    <= sync2_q;
            press_q   <= sync2_q & ~prev_q;   // rising edge
            release_q <= ~sync2_q & prev_q;   // falling edge
            if (status_hit && req_i.be != 4'b0000) begin
                count_q <= 8'd0;              // any write clears
            end else if (press_q) begin
                count_q <= count_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (status_hit && req_i.be == 4'b0000) begin
            rdata_q <= {23'd0, sync2_q, count_q};
        end
    end

    always_comb begin
        irq_o    = '0;
        irq_o[1] = press_q;
        irq_o[2] = release_q;
    end

    assign rdata_o = rdata_q;

endmodule

//--- verilog/platform_top.sv
////////////////////////////////////////////////////////////
// data port only, no stall, one request per cycle at most
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module platform_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o,
    input  logic              btn_i,
    output logic              mti_o,
    output logic              mei_o
);

    soc_pkg::dev_sel_t           sel;
    logic [31:0]                 ram_rdata;
    logic [31:0]                 tmr_rdata;
    logic [31:0]                 irq_rdata;
    logic [31:0]                 btn_rdata;
    logic [soc_pkg::IRQ_COUNT:1] btn_irq;

    ////////////////////////////////////////////////////////////
    // fabric
    ////////////////////////////////////////////////////////////
    bus_fabric u_bus_fabric (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .sel_o       (sel),
        .ram_rdata_i (ram_rdata),
        .tmr_rdata_i (tmr_rdata),
        .irq_rdata_i (irq_rdata),
        .btn_rdata_i (btn_rdata),
        .rsp_o       (rsp_o)
    );

    ////////////////////////////////////////////////////////////
    // devices
    ////////////////////////////////////////////////////////////
    scratch_ram u_scratch_ram (
        .clk     (clk),
        .req_i   (req_i),
        .sel_i   (sel.ram),
        .rdata_o (ram_rdata)
    );

    machine_timer u_machine_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .sel_i   (sel.timer),
        .rdata_o (tmr_rdata),
        .mti_o   (mti_o)
    );

    irq_controller u_irq_controller (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .sel_i   (sel.irq),
        .src_i   (btn_irq),     // ids 1 press, 2 release
        .rdata_o (irq_rdata),
        .mei_o   (mei_o)
    );

    button_port u_button_port (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .sel_i   (sel.periph),
        .btn_i   (btn_i),
        .rdata_o (btn_rdata),
        .irq_o   (btn_irq)
    );

endmodule

//--- testbench/tb_platform.sv
////////////////////////////////////////////////////////////
// data-port master driving platform_top
// inputs change 0.5 ns after each rising edge
// the model steps once per edge after reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_platform;

    localparam realtime CLK_PERIOD  = 4.0;
    localparam int      TEST_CYCLES = 600;

    logic              clk;
    logic              rst_n_i;
    soc_pkg::bus_req_t req;
    soc_pkg::bus_rsp_t rsp;
    logic              btn;
    logic              mti;
    logic              mei;

    // reference model state
    logic [31:0]                 ram_m [soc_pkg::RAM_WORDS];
    logic [63:0]                 mt_base;    // mtime value at edge number base_cnt
    logic [63:0]                 base_cnt;
    logic [63:0]                 edge_cnt;   // edges since reset release
    logic [63:0]                 cmp_m;
    logic [soc_pkg::IRQ_COUNT:1] en_m;
    logic [soc_pkg::IRQ_COUNT:1] pend_m;
    logic [7:0]                  count_m;
    logic [4:1]                  btn_hist;   // btn sampled one to four edges back

    // expectations for the edge being checked
    logic        chk_on;
    logic        exp_valid;
    logic        exp_read;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic        exp_mti;
    logic        exp_mei;

    logic [31:0] lfsr_q;
    int          mismatch_cnt;
    int          fail_cnt;

    platform_top u_platform_top (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req),
        .rsp_o   (rsp),
        .btn_i   (btn),
        .mti_o   (mti),
        .mei_o   (mei)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random source and helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] res;
        res = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            res    = {res[30:0], lfsr_q[0]};
        end
        return res;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        logic [7:0] a;
        a = 8'(i);
        return {a, ~a, a ^ 8'h3c, {a[3:0], a[7:4]}};
    endfunction

    function automatic soc_pkg::region_e region_of(input logic [31:0] addr);
        if (addr[31:28] < soc_pkg::TIMER_BASE) begin
            return soc_pkg::REGION_RAM;
        end else if (addr[31:28] < soc_pkg::IRQ_BASE) begin
            return soc_pkg::REGION_TIMER;
        end else if (addr[31:28] < soc_pkg::PERIPH_BASE) begin
            return soc_pkg::REGION_IRQ;
        end
        return soc_pkg::REGION_PERIPH;
    endfunction

    function automatic logic [63:0] mtime_now();
        return mt_base + edge_cnt - base_cnt;   // value before the next edge
    endfunction

    function automatic logic [31:0] lowest_active();
        logic [31:0] id;
        id = 32'd0;
        for (int i = 1; i <= soc_pkg::IRQ_COUNT; i++) begin
            if (pend_m[i] && en_m[i]) begin
                id = 32'(i);
                break;
            end
        end
        return id;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] res;
        logic [63:0] mt;
        res = 32'd0;
        mt  = mtime_now();
        case (region_of(addr))
            soc_pkg::REGION_RAM: res = ram_m[addr[soc_pkg::RAM_AW+1:2]];
            soc_pkg::REGION_TIMER: begin
                case (addr[3:0])
                    soc_pkg::MTIME_LO:    res = mt[31:0];
                    soc_pkg::MTIME_HI:    res = mt[63:32];
                    soc_pkg::MTIMECMP_LO: res = cmp_m[31:0];
                    soc_pkg::MTIMECMP_HI: res = cmp_m[63:32];
                    default:              res = 32'd0;
                endcase
            end
            soc_pkg::REGION_IRQ: begin
                case (addr[3:0])
                    soc_pkg::IRQ_ENABLE:  res[soc_pkg::IRQ_COUNT:1] = en_m;
                    soc_pkg::IRQ_PENDING: res[soc_pkg::IRQ_COUNT:1] = pend_m;
                    soc_pkg::IRQ_CLAIM:   res = lowest_active();
                    default:              res = 32'd0;
                endcase
            end
            default: res = {23'd0, btn_hist[2], count_m};   // level after two flops
        endcase
        return res;
    endfunction

    task automatic model_reset();
        mt_base  = 64'd0;
        base_cnt = 64'd0;
        edge_cnt = 64'd0;
        cmp_m    = '1;
        en_m     = '0;
        pend_m   = '0;
        count_m  = 8'd0;
        btn_hist = '0;
        exp_mti  = 1'b0;
        exp_mei  = 1'b0;
    endtask

    task automatic model_step(input soc_pkg::bus_req_t r, input logic b);
        logic [63:0]                 mt;
        logic [soc_pkg::IRQ_COUNT:1] clr;
        logic [soc_pkg::IRQ_COUNT:1] src;
        logic [31:0]                 id;
        logic                        wr;
        logic                        rd;
        logic                        cnt_clr;
        logic [3:0]                  off;
        logic [soc_pkg::RAM_AW-1:0]  idx;
        mt      = mtime_now();
        wr      = r.en && (r.be != 4'b0000);
        rd      = r.en && (r.be == 4'b0000);
        off     = r.addr[3:0];
        idx     = r.addr[soc_pkg::RAM_AW+1:2];
        clr     = '0;
        cnt_clr = 1'b0;
        src     = '0;
        src[1]  = btn_hist[3] & ~btn_hist[4];   // press pulse
        src[2]  = ~btn_hist[3] & btn_hist[4];   // release pulse
        exp_mti = (mt >= cmp_m);
        case (region_of(r.addr))
            soc_pkg::REGION_RAM: begin
                if (wr) ram_m[idx] = merge_bytes(ram_m[idx], r.wdata, r.be);
            end
            soc_pkg::REGION_TIMER: begin
                if (wr && off == soc_pkg::MTIME_LO) begin
                    mt[31:0] = merge_bytes(mt[31:0], r.wdata, r.be);
                    mt_base  = mt;
                    base_cnt = edge_cnt + 64'd1;
                end else if (wr && off == soc_pkg::MTIME_HI) begin
                    mt[63:32] = merge_bytes(mt[63:32], r.wdata, r.be);
                    mt_base   = mt;
                    base_cnt  = edge_cnt + 64'd1;
                end else if (wr && off == soc_pkg::MTIMECMP_LO) begin
                    cmp_m[31:0] = merge_bytes(cmp_m[31:0], r.wdata, r.be);
                end else if (wr && off == soc_pkg::MTIMECMP_HI) begin
                    cmp_m[63:32] = merge_bytes(cmp_m[63:32], r.wdata, r.be);
                end
            end
            soc_pkg::REGION_IRQ: begin
                if (rd && off == soc_pkg::IRQ_CLAIM) begin
                    id = lowest_active();
                    for (int i = 1; i <= soc_pkg::IRQ_COUNT; i++) begin
                        if (32'(i) == id) clr[i] = 1'b1;
                    end
                end
                if (wr && off == soc_pkg::IRQ_PENDING) clr = clr | r.wdata[soc_pkg::IRQ_COUNT:1];
                if (wr && off == soc_pkg::IRQ_ENABLE) en_m = r.wdata[soc_pkg::IRQ_COUNT:1];
            end
            default: begin
                if (wr && off == soc_pkg::BTN_STATUS) cnt_clr = 1'b1;
            end
        endcase
        if (cnt_clr) begin
            count_m = 8'd0;
        end else if (src[1]) begin
            count_m = count_m + 8'd1;
        end
        pend_m   = (pend_m & ~clr) | src;
        exp_mei  = |(pend_m & en_m);
        btn_hist = {btn_hist[3:1], b};
        edge_cnt = edge_cnt + 64'd1;
    endtask

    ////////////////////////////////////////////////////////////
    // comparator stepping once per rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst_n_i) begin
            model_reset();
            chk_on = 1'b0;
        end else begin
            chk_on    = 1'b1;
            exp_valid = req.en;
            exp_read  = req.en && (req.be == 4'b0000);
            exp_addr  = req.addr;
            exp_data  = ref_read(req.addr);
            model_step(req, btn);
        end
        #1;   // outputs settled after the edge
        if (chk_on) begin
            assert (rsp.valid === exp_valid) else begin
                mismatch_cnt++;
                $display("MISMATCH %0t: response valid %b, expected %b", $time, rsp.valid,
                         exp_valid);
            end
            if (exp_read) begin
                assert (rsp.rdata === exp_data) else begin
                    mismatch_cnt++;
                    $display("MISMATCH %0t: read of %h returned %h, expected %h", $time,
                             exp_addr, rsp.rdata, exp_data);
                end
            end
            assert (mti === exp_mti) else begin
                mismatch_cnt++;
                $display("MISMATCH %0t: mti is %b, expected %b", $time, mti, exp_mti);
            end
            assert (mei === exp_mei) else begin
                mismatch_cnt++;
                $display("MISMATCH %0t: mei is %b, expected %b", $time, mei, exp_mei);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic issue(input logic [3:0] be, input logic [31:0] addr,
                         input logic [31:0] wdata);
        req.en    = 1'b1;
        req.be    = be;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle(input int n);
        req = '0;
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    // response is registered at the request edge
    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        issue(4'b0000, addr, 32'd0);
        data = rsp.rdata;
    endtask

    task automatic wait_for_mei(input int limit);
        int n;
        n = 0;
        while (!mei && n < limit) begin
            idle(1);
            n++;
        end
        assert (mei) else begin
            fail_cnt++;
            $display("mei did not rise within %0d cycles of the button press", limit);
        end
    endtask

    initial begin
        logic [31:0] addr_q [$];
        logic [31:0] addr;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [3:0]  be;
        logic [63:0] target;
        int          n;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        req          = '0;
        btn          = 1'b0;
        lfsr_q       = 32'h1fdeab68;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        repeat (5) @(posedge clk);
        #0.5;
        rst_n_i = 1'b1;

        // ram fill followed by random byte writes and back-to-back reads
        for (int i = 0; i < soc_pkg::RAM_WORDS; i++) begin
            issue(4'hF, {22'd0, 8'(i), 2'b00}, fill_word(i));
        end
        for (int i = 0; i < 40; i++) begin
            addr = {3'b000, take_bits(1) == 32'd1, 16'h0, 10'(take_bits(10)), 2'b00};
            be   = 4'(take_bits(4));
            if (be == 4'b0000) be = 4'hF;
            addr_q.push_back(addr);
            issue(be, addr, take_bits(32));
        end
        foreach (addr_q[i]) begin
            issue(4'b0000, addr_q[i], 32'd0);
        end
        idle(2);

        // mtime reads k cycles apart
        read_word(32'h2000_0000, d1);
        idle(4);
        read_word(32'h2000_0000, d2);
        assert (d2 - d1 == 32'd5) else begin
            mismatch_cnt++;
            $display("MISMATCH %0t: mtime advanced by %0d over 5 cycles", $time, d2 - d1);
        end
        issue(4'hF, 32'h2000_0000, 32'h7fff_0000);
        idle(6);
        read_word(32'h2000_0000, d1);
        assert (d1 == 32'h7fff_0006) else begin
            mismatch_cnt++;
            $display("MISMATCH %0t: mtime read %h after write, expected 7fff0006", $time, d1);
        end
        issue(4'hF, 32'h2000_000C, 32'h0000_0100);
        issue(4'hF, 32'h2000_0008, 32'h1234_5678);
        issue(4'b0000, 32'h2000_0008, 32'd0);
        issue(4'b0000, 32'h2000_000C, 32'd0);
        idle(1);

        // timer interrupt at mtime plus 20
        target = mtime_now() + 64'd20;
        issue(4'hF, 32'h2000_0008, target[31:0]);
        issue(4'hF, 32'h2000_000C, target[63:32]);
        n = 0;
        idle(0);
        while (!mti && n < 40) begin
            idle(1);
            n++;
        end
        assert (mti) else begin
            fail_cnt++;
            $display("mti never rose after mtimecmp was programmed");
        end
        idle(5);
        issue(4'hF, 32'h2000_000C, 32'hffff_ffff);
        idle(2);
        assert (!mti) else begin
            fail_cnt++;
            $display("mti stayed high after mtimecmp was raised");
        end

        // button press and claims before a release with source 2 disabled
        issue(4'hF, 32'h3000_0000, 32'h0000_0002);
        idle(0);
        btn = 1'b1;
        wait_for_mei(10);
        issue(4'b0000, 32'h8000_0000, 32'd0);
        read_word(32'h3000_0008, d1);
        read_word(32'h3000_0008, d2);
        assert (d1 == 32'd1 && d2 == 32'd0) else begin
            mismatch_cnt++;
            $display("MISMATCH %0t: claims returned %0d and %0d, expected 1 and 0", $time,
                     d1, d2);
        end
        idle(0);
        btn = 1'b0;
        idle(6);
        issue(4'b0000, 32'h3000_0004, 32'd0);
        issue(4'hF, 32'h3000_0004, 32'h0000_0004);
        issue(4'b0000, 32'h3000_0004, 32'd0);

        // region routing across aliased addresses
        issue(4'hF, 32'h5000_0000, 32'h0000_0006);
        issue(4'b0000, 32'h0000_0000, 32'd0);
        issue(4'b0000, 32'h7000_0000, 32'd0);
        issue(4'hF, 32'hC000_0000, 32'd0);
        issue(4'b0000, 32'hF000_0000, 32'd0);
        issue(4'b0000, 32'h1000_0000, 32'd0);
        issue(4'hF, 32'h2000_0008, 32'hdead_beef);
        issue(4'b0000, 32'h0000_0008, 32'd0);
        issue(4'b0000, 32'h2000_0008, 32'd0);
        issue(4'hF, 32'h1000_0010, 32'h0bad_cafe);
        issue(4'b0000, 32'h0000_0010, 32'd0);
        issue(4'b0000, 32'h3000_0000, 32'd0);
        issue(4'b0000, 32'h8000_0000, 32'd0);
        idle(3);

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog stopped the run before the test sequence finished");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sim.f
verilog/soc_pkg.sv
verilog/bus_fabric.sv
verilog/scratch_ram.sv
verilog/machine_timer.sv
verilog/irq_controller.sv
verilog/button_port.sv
verilog/platform_top.sv
testbench/tb_platform.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -Mdir obj_dir --top-module tb_platform -o tb_platform -f sim.f

./obj_dir/tb_platform | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
